/* Makefile */
# Verilator build of the accumulator core testbench.
TOP = mythCoreTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f vlog.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)

# The log decides the result, the simulator's exit status is not used.
run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^TB PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* hdl/execUnit.sv */
`default_nettype none

`include "myth_defines.svh"

module execUnit
(
  input  wire                      clk,
  input  wire                      reset,
  input  wire mythCorePkg::phaseT  phase,
  input  wire mythCorePkg::dataT   memData,
  output logic                     operandFetch,
  output logic                     jumpLoad,
  output mythCorePkg::dataT        jumpTarget,
  output logic                     showRegs,
  output logic                     showJump,
  output mythCorePkg::dataT        regA,
  output mythCorePkg::dataT        regB
);

  mythIsaPkg::opcodeT      opcode; // Held for the WRITE phase.
  mythCorePkg::dataT       regR;
  mythCorePkg::dataT       aluResult;
  logic [`MYTH_DATA_W:0]   carrySum;
  logic                    isRead;
  logic                    isWrite;
  logic                    isPair;
  logic                    rNonZero;

  assign isRead   = (phase == mythCorePkg::READ);
  assign isWrite  = (phase == mythCorePkg::WRITE);
  assign rNonZero = (regR != '0);
  assign carrySum = {1'b0, regA} + {1'b0, regB};

  // ************************************************************
  // READ phase decode, straight from the memory data
  // ************************************************************

  always_comb
  begin
    case (memData)
      mythIsaPkg::opcNa, mythIsaPkg::opcNb, mythIsaPkg::opcNr,
      mythIsaPkg::opcNj, mythIsaPkg::opcNt, mythIsaPkg::opcNf: isPair = 1'b1;
      default: isPair = 1'b0;
    endcase
  end

  assign operandFetch = isRead && isPair;
  assign showRegs     = isRead && (memData == mythIsaPkg::opcRdy);
  assign showJump     = isWrite && (opcode == mythIsaPkg::opcNj); // NJ is always taken.

  // The ALU. Opcodes outside the group hand R back unchanged.
  always_comb
  begin
    case (memData)
      mythIsaPkg::opcIda: aluResult = regA;
      mythIsaPkg::opcIdb: aluResult = regB;
      mythIsaPkg::opcOca: aluResult = ~regA;
      mythIsaPkg::opcOcb: aluResult = ~regB;
      mythIsaPkg::opcSla: aluResult = regA << 1;
      mythIsaPkg::opcSlb: aluResult = regB << 1;
      mythIsaPkg::opcSra: aluResult = regA >> 1;
      mythIsaPkg::opcSrb: aluResult = regB >> 1;
      mythIsaPkg::opcAnd: aluResult = regA & regB;
      mythIsaPkg::opcIor: aluResult = regA | regB;
      mythIsaPkg::opcEor: aluResult = regA ^ regB;
      mythIsaPkg::opcAdd: aluResult = carrySum[`MYTH_DATA_W-1:0];
      mythIsaPkg::opcCar: aluResult = mythCorePkg::dataT'(carrySum[`MYTH_DATA_W]);
      mythIsaPkg::opcAlb: aluResult = (regA < regB) ? '1 : '0;
      mythIsaPkg::opcAeb: aluResult = (regA == regB) ? '1 : '0;
      mythIsaPkg::opcAgb: aluResult = (regA > regB) ? '1 : '0;
      default: aluResult = regR;
    endcase
  end

  // Jump decision. Register forms resolve in READ, immediate forms in WRITE.
  always_comb
  begin
    jumpLoad   = 1'b0;
    jumpTarget = memData;
    if (isRead)
    begin
      jumpTarget = regR;
      case (memData)
        mythIsaPkg::opcRj: jumpLoad = 1'b1;
        mythIsaPkg::opcRt: jumpLoad = rNonZero;
        mythIsaPkg::opcRf: jumpLoad = !rNonZero;
        default: jumpLoad = 1'b0;
      endcase
    end
    else if (isWrite)
    begin
      case (opcode)
        mythIsaPkg::opcNj: jumpLoad = 1'b1;
        mythIsaPkg::opcNt: jumpLoad = rNonZero;
        mythIsaPkg::opcNf: jumpLoad = !rNonZero;
        default: jumpLoad = 1'b0;
      endcase
    end
  end

  // ************************************************************
  // Register file
  // ************************************************************

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      opcode <= mythIsaPkg::opcNop;
      regA   <= '0;
      regB   <= '0;
      regR   <= '0;
    end
    else if (isRead)
    begin
      opcode <= memData;
      case (memData)
        mythIsaPkg::opcP1: regR <= regR + 8'd1;
        mythIsaPkg::opcP2: regR <= regR + 8'd2;
        mythIsaPkg::opcP3: regR <= regR + 8'd3;
        mythIsaPkg::opcP4: regR <= regR + 8'd4;
        mythIsaPkg::opcM1: regR <= regR - 8'd1;
        mythIsaPkg::opcM2: regR <= regR - 8'd2;
        mythIsaPkg::opcM3: regR <= regR - 8'd3;
        mythIsaPkg::opcM4: regR <= regR - 8'd4;
        mythIsaPkg::opcRa: regA <= regR;
        mythIsaPkg::opcRb: regB <= regR;
        default: regR <= aluResult;
      endcase
    end
    else if (isWrite)
    begin
      case (opcode) // Immediate byte is on memData now.
        mythIsaPkg::opcNa: regA <= memData;
        mythIsaPkg::opcNb: regB <= memData;
        mythIsaPkg::opcNr: regR <= memData;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/fetchUnit.sv */
`default_nettype none

`include "myth_defines.svh"

module fetchUnit
(
  input  wire                      clk,
  input  wire                      reset,
  input  wire                      operandFetch,
  input  wire                      jumpLoad,
  input  wire mythCorePkg::dataT   jumpTarget,
  output mythCorePkg::phaseT       phase,
  output mythCorePkg::addrT        memAddr
);

  localparam mythCorePkg::dataT codePage   = `MYTH_CODE_PAGE;
  localparam mythCorePkg::dataT globalPage = `MYTH_GLOBAL_PAGE;

  mythCorePkg::dataT pc;
  mythCorePkg::dataT page;

  // ************************************************************
  // Address formation
  // ************************************************************

  // The upper half of the pc range is shared code in the global page.
  assign page = pc[`MYTH_OFFSET_W] ? globalPage : codePage;

  // Page in the high byte and the offset zero extended in the low byte. The
  // memory samples this at the end of the cycle, so FETCH shows the opcode
  // address and a READ with an operand shows the address of the immediate byte.
  assign memAddr = {page, mythCorePkg::dataT'(pc[`MYTH_OFFSET_W-1:0])};

  // ************************************************************
  // Phase sequencer and program counter
  // ************************************************************

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      phase <= mythCorePkg::FETCH;
      pc    <= '0;
    end
    else
    begin
      case (phase)
        mythCorePkg::FETCH:
        begin
          phase <= mythCorePkg::READ;
          pc    <= pc + 8'd1; // Step past the opcode.
        end

        mythCorePkg::READ:
        begin
          phase <= mythCorePkg::WRITE;
          if (jumpLoad)
            pc <= jumpTarget; // Register forms jump here.
          else if (operandFetch)
            pc <= pc + 8'd1; // Step past the immediate byte.
        end

        mythCorePkg::WRITE:
        begin
          phase <= mythCorePkg::FETCH;
          if (jumpLoad)
            pc <= jumpTarget; // Immediate forms jump here.
        end

        default:
          phase <= mythCorePkg::FETCH;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/mythCore.sv */
`default_nettype none

module mythCore
(
  input  wire                      clk,
  input  wire                      reset,
  output mythCorePkg::addrT        memAddr,
  input  wire mythCorePkg::dataT   memData,
  output mythCorePkg::segT         seg1,
  output mythCorePkg::segT         seg2,
  output mythCorePkg::segT         seg3,
  output mythCorePkg::segT         seg4,
  output mythCorePkg::segT         seg5,
  output mythCorePkg::segT         seg6
);

  mythCorePkg::phaseT  phase;
  logic                operandFetch;
  logic                jumpLoad;
  mythCorePkg::dataT   jumpTarget; // Also the value shown on digits 1 and 2.
  logic                showRegs;
  logic                showJump;
  mythCorePkg::dataT   regA;
  mythCorePkg::dataT   regB;

  // Sequencer and program counter.
  fetchUnit i_fetchUnit
  (
    .clk          (clk),
    .reset        (reset),
    .operandFetch (operandFetch),
    .jumpLoad     (jumpLoad),
    .jumpTarget   (jumpTarget),
    .phase        (phase),
    .memAddr      (memAddr)
  );

  execUnit i_execUnit
  (
    .clk          (clk),
    .reset        (reset),
    .phase        (phase),
    .memData      (memData),
    .operandFetch (operandFetch),
    .jumpLoad     (jumpLoad),
    .jumpTarget   (jumpTarget),
    .showRegs     (showRegs),
    .showJump     (showJump),
    .regA         (regA),
    .regB         (regB)
  );

  segDisplay i_segDisplay
  (
    .clk        (clk),
    .reset      (reset),
    .showRegs   (showRegs),
    .showJump   (showJump),
    .regA       (regA),
    .regB       (regB),
    .jumpTarget (jumpTarget),
    .seg1       (seg1),
    .seg2       (seg2),
    .seg3       (seg3),
    .seg4       (seg4),
    .seg5       (seg5),
    .seg6       (seg6)
  );

endmodule

`default_nettype wire

/* hdl/mythCorePkg.sv */
`default_nettype none

`include "myth_defines.svh"

package mythCorePkg;

  typedef logic [`MYTH_DATA_W-1:0] dataT;
  typedef logic [`MYTH_ADDR_W-1:0] addrT;

  // Each instruction walks through these three phases in order.
  typedef enum logic [1:0]
  {
    FETCH = 2'd0,
    READ  = 2'd1,
    WRITE = 2'd2
  } phaseT;

  // A zero bit lights the segment.
  typedef logic [`MYTH_SEG_W-1:0] segT;

endpackage

`default_nettype wire

/* hdl/mythIsaPkg.sv */
`default_nettype none

`include "myth_defines.svh"

package mythIsaPkg;

  typedef logic [`MYTH_DATA_W-1:0] opcodeT;

  // ************************************************************
  // SYS and ADJUST groups
  // ************************************************************

  localparam opcodeT opcNop = 8'h00;
  localparam opcodeT opcRdy = 8'h05; // Shows A and B on the display.

  localparam opcodeT opcP4 = 8'h08;
  localparam opcodeT opcP1 = 8'h09;
  localparam opcodeT opcP2 = 8'h0A;
  localparam opcodeT opcP3 = 8'h0B;
  localparam opcodeT opcM4 = 8'h0C;
  localparam opcodeT opcM3 = 8'h0D;
  localparam opcodeT opcM2 = 8'h0E;
  localparam opcodeT opcM1 = 8'h0F;

  // ************************************************************
  // ALU group, all sixteen work on A and B and write R
  // ************************************************************

  localparam opcodeT opcIda = 8'h10;
  localparam opcodeT opcIdb = 8'h11;
  localparam opcodeT opcOca = 8'h12;
  localparam opcodeT opcOcb = 8'h13;
  localparam opcodeT opcSla = 8'h14;
  localparam opcodeT opcSlb = 8'h15;
  localparam opcodeT opcSra = 8'h16;
  localparam opcodeT opcSrb = 8'h17;
  localparam opcodeT opcAnd = 8'h18;
  localparam opcodeT opcIor = 8'h19;
  localparam opcodeT opcEor = 8'h1A;
  localparam opcodeT opcAdd = 8'h1B;
  localparam opcodeT opcCar = 8'h1C;
  localparam opcodeT opcAlb = 8'h1D;
  localparam opcodeT opcAeb = 8'h1E;
  localparam opcodeT opcAgb = 8'h1F;

  // Pairs with an immediate byte as source.
  localparam opcodeT opcNr = 8'h84;
  localparam opcodeT opcNj = 8'h8A;
  localparam opcodeT opcNt = 8'h8B;
  localparam opcodeT opcNf = 8'h8C;
  localparam opcodeT opcNa = 8'h8E;
  localparam opcodeT opcNb = 8'h8F;

  // Pairs with R as source.
  localparam opcodeT opcRj = 8'hCA;
  localparam opcodeT opcRt = 8'hCB;
  localparam opcodeT opcRf = 8'hCC;
  localparam opcodeT opcRa = 8'hCE;
  localparam opcodeT opcRb = 8'hCF;

endpackage

`default_nettype wire

/* hdl/myth_defines.svh */
`ifndef MYTH_DEFINES_SVH
`define MYTH_DEFINES_SVH

// Datapath width of the accumulator core.
`define MYTH_DATA_W 8

// Width of the external program memory address.
`define MYTH_ADDR_W 16

// Offset bits taken from the program counter. The next pc bit picks the page.
`define MYTH_OFFSET_W 7

// ************************************************************
// Memory pages
// ************************************************************

`define MYTH_CODE_PAGE 0     // Offsets below 128 fetch from here.
`define MYTH_GLOBAL_PAGE 255 // Offsets of 128 and above fetch from here.

// Active-low segment pattern of one display digit.
`define MYTH_SEG_W 7

`endif

/* hdl/segDisplay.sv */
`default_nettype none

module segDisplay
(
  input  wire                      clk,
  input  wire                      reset,
  input  wire                      showRegs,
  input  wire                      showJump,
  input  wire mythCorePkg::dataT   regA,
  input  wire mythCorePkg::dataT   regB,
  input  wire mythCorePkg::dataT   jumpTarget,
  output mythCorePkg::segT         seg1,
  output mythCorePkg::segT         seg2,
  output mythCorePkg::segT         seg3,
  output mythCorePkg::segT         seg4,
  output mythCorePkg::segT         seg5,
  output mythCorePkg::segT         seg6
);

  // Hex glyph for one nibble, segment a in bit 0, inverted for the display.
  function automatic mythCorePkg::segT hexGlyph(input logic [3:0] nibble);
    mythCorePkg::segT lit;
    case (nibble)
      4'h0: lit = 7'h3F;
      4'h1: lit = 7'h06;
      4'h2: lit = 7'h5B;
      4'h3: lit = 7'h4F;
      4'h4: lit = 7'h66;
      4'h5: lit = 7'h6D;
      4'h6: lit = 7'h7D;
      4'h7: lit = 7'h07;
      4'h8: lit = 7'h7F;
      4'h9: lit = 7'h67;
      4'hA: lit = 7'h77;
      4'hB: lit = 7'h7C;
      4'hC: lit = 7'h39;
      4'hD: lit = 7'h5E;
      4'hE: lit = 7'h79;
      default: lit = 7'h71;
    endcase
    return ~lit;
  endfunction

  // ************************************************************
  // Digit pairs, each held until its next strobe
  // ************************************************************

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      seg1 <= '1; // Blank.
      seg2 <= '1;
      seg3 <= '1;
      seg4 <= '1;
      seg5 <= '1;
      seg6 <= '1;
    end
    else
    begin
      if (showJump)
      begin
        seg1 <= hexGlyph(jumpTarget[3:0]);
        seg2 <= hexGlyph(jumpTarget[7:4]);
      end
      if (showRegs)
      begin
        seg3 <= hexGlyph(regA[3:0]);
        seg4 <= hexGlyph(regA[7:4]);
        seg5 <= hexGlyph(regB[3:0]);
        seg6 <= hexGlyph(regB[7:4]);
      end
    end
  end

endmodule

`default_nettype wire

/* tests/mythCoreTb.sv */
`default_nettype none

`include "myth_defines.svh"

module mythCoreTb;

  localparam int clockPeriod = 20;
  localparam int cycleLimit  = 100000; // Watchdog limit in clock cycles.

  logic               clk;
  logic               reset;
  mythCorePkg::addrT  memAddr;
  mythCorePkg::dataT  memData = '0;
  mythCorePkg::segT   seg1;
  mythCorePkg::segT   seg2;
  mythCorePkg::segT   seg3;
  mythCorePkg::segT   seg4;
  mythCorePkg::segT   seg5;
  mythCorePkg::segT   seg6;

  mythCorePkg::dataT  mem [0:65535];   // Program memory as the core sees it.
  mythCorePkg::dataT  image [0:255];   // The same program indexed by pc.
  mythCorePkg::dataT  progQ [$];
  logic [31:0]        rngState = 32'hb6fdc75f;

  // Reference model state.
  mythCorePkg::dataT  modelPc;
  mythCorePkg::dataT  modelA;
  mythCorePkg::dataT  modelB;
  mythCorePkg::dataT  modelR;
  mythCorePkg::segT   expSeg [1:6];

  mythCore i_mythCore
  (
    .clk     (clk),
    .reset   (reset),
    .memAddr (memAddr),
    .memData (memData),
    .seg1    (seg1),
    .seg2    (seg2),
    .seg3    (seg3),
    .seg4    (seg4),
    .seg5    (seg5),
    .seg6    (seg6)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clockPeriod / 2) clk = ~clk;
  end

  // Synchronous memory. The byte arrives one clock after its address.
  always @(posedge clk)
    memData <= mem[memAddr];

  initial
  begin
    repeat (cycleLimit) @(posedge clk);
    abortRun($sformatf("Timeout: the run did not finish within %0d cycles.", cycleLimit));
  end

  // ************************************************************
  // Helpers
  // ************************************************************

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "Stopped at the first failure.");
  endtask

  function automatic mythCorePkg::dataT randByte();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return mythCorePkg::dataT'(rngState);
  endfunction

  // Page 0 below offset 128 and the global page from 128 upward.
  function automatic mythCorePkg::addrT pcAddr(input mythCorePkg::dataT pc);
    logic [7:0] page;
    page = pc[7] ? 8'(`MYTH_GLOBAL_PAGE) : 8'(`MYTH_CODE_PAGE);
    return {page, 1'b0, pc[6:0]};
  endfunction

  function automatic mythCorePkg::segT glyphOf(input logic [3:0] nibble);
    logic [6:0] lightSegs; // Segment a in bit 0.
    case (nibble)
      4'h0: lightSegs = 7'h3F;
      4'h1: lightSegs = 7'h06;
      4'h2: lightSegs = 7'h5B;
      4'h3: lightSegs = 7'h4F;
      4'h4: lightSegs = 7'h66;
      4'h5: lightSegs = 7'h6D;
      4'h6: lightSegs = 7'h7D;
      4'h7: lightSegs = 7'h07;
      4'h8: lightSegs = 7'h7F;
      4'h9: lightSegs = 7'h67;
      4'hA: lightSegs = 7'h77;
      4'hB: lightSegs = 7'h7C;
      4'hC: lightSegs = 7'h39;
      4'hD: lightSegs = 7'h5E;
      4'hE: lightSegs = 7'h79;
      default: lightSegs = 7'h71;
    endcase
    return ~lightSegs;
  endfunction

  function automatic mythCorePkg::dataT aluModel(input mythIsaPkg::opcodeT op);
    int sum;
    sum = int'(modelA) + int'(modelB);
    case (op)
      mythIsaPkg::opcIda: return modelA;
      mythIsaPkg::opcIdb: return modelB;
      mythIsaPkg::opcOca: return ~modelA;
      mythIsaPkg::opcOcb: return ~modelB;
      mythIsaPkg::opcSla: return {modelA[6:0], 1'b0};
      mythIsaPkg::opcSlb: return {modelB[6:0], 1'b0};
      mythIsaPkg::opcSra: return {1'b0, modelA[7:1]};
      mythIsaPkg::opcSrb: return {1'b0, modelB[7:1]};
      mythIsaPkg::opcAnd: return modelA & modelB;
      mythIsaPkg::opcIor: return modelA | modelB;
      mythIsaPkg::opcEor: return modelA ^ modelB;
      mythIsaPkg::opcAdd: return mythCorePkg::dataT'(sum);
      mythIsaPkg::opcCar: return (sum > 255) ? 8'd1 : 8'd0;
      mythIsaPkg::opcAlb: return (modelA < modelB) ? 8'hFF : 8'h00;
      mythIsaPkg::opcAeb: return (modelA == modelB) ? 8'hFF : 8'h00;
      default: return (modelA > modelB) ? 8'hFF : 8'h00; // AGB.
    endcase
  endfunction

  // ************************************************************
  // Reference model that runs one whole instruction per call
  // ************************************************************

  task automatic modelStep();
    mythIsaPkg::opcodeT op;
    mythCorePkg::dataT  imm;
    op = image[modelPc];
    imm = 8'h00;
    modelPc = modelPc + 8'd1;
    case (op)
      mythIsaPkg::opcNa, mythIsaPkg::opcNb, mythIsaPkg::opcNr,
      mythIsaPkg::opcNj, mythIsaPkg::opcNt, mythIsaPkg::opcNf:
      begin
        imm = image[modelPc];
        modelPc = modelPc + 8'd1;
      end
      default: ;
    endcase
    case (op)
      mythIsaPkg::opcP1: modelR = modelR + 8'd1;
      mythIsaPkg::opcP2: modelR = modelR + 8'd2;
      mythIsaPkg::opcP3: modelR = modelR + 8'd3;
      mythIsaPkg::opcP4: modelR = modelR + 8'd4;
      mythIsaPkg::opcM1: modelR = modelR - 8'd1;
      mythIsaPkg::opcM2: modelR = modelR - 8'd2;
      mythIsaPkg::opcM3: modelR = modelR - 8'd3;
      mythIsaPkg::opcM4: modelR = modelR - 8'd4;
      mythIsaPkg::opcRa: modelA = modelR;
      mythIsaPkg::opcRb: modelB = modelR;
      mythIsaPkg::opcRj: modelPc = modelR;
      mythIsaPkg::opcRt: if (modelR != 8'd0) modelPc = modelR;
      mythIsaPkg::opcRf: if (modelR == 8'd0) modelPc = modelR;
      mythIsaPkg::opcNa: modelA = imm;
      mythIsaPkg::opcNb: modelB = imm;
      mythIsaPkg::opcNr: modelR = imm;
      mythIsaPkg::opcNt: if (modelR != 8'd0) modelPc = imm;
      mythIsaPkg::opcNf: if (modelR == 8'd0) modelPc = imm;
      mythIsaPkg::opcNj:
      begin
        modelPc = imm;
        expSeg[1] = glyphOf(imm[3:0]);
        expSeg[2] = glyphOf(imm[7:4]);
      end
      mythIsaPkg::opcRdy:
      begin
        expSeg[3] = glyphOf(modelA[3:0]);
        expSeg[4] = glyphOf(modelA[7:4]);
        expSeg[5] = glyphOf(modelB[3:0]);
        expSeg[6] = glyphOf(modelB[7:4]);
      end
      default:
        if (op >= mythIsaPkg::opcIda && op <= mythIsaPkg::opcAgb)
          modelR = aluModel(op);
    endcase
  endtask

  // ************************************************************
  // Checks and program handling
  // ************************************************************

  task automatic checkAddr(input string name, input mythCorePkg::addrT got,
                           input mythCorePkg::addrT expected);
    if (got !== expected)
      abortRun($sformatf("Mismatch at time %0t: %s is %h, expected %h",
                         $time, name, got, expected));
  endtask

  task automatic checkSeg(input string name, input mythCorePkg::segT got,
                          input mythCorePkg::segT expected);
    if (got !== expected)
      abortRun($sformatf("Mismatch at time %0t: %s is %h, expected %h",
                         $time, name, got, expected));
  endtask

  // Called in the FETCH cycle of the next instruction.
  task automatic checkState();
    checkAddr("memAddr", memAddr, pcAddr(modelPc));
    checkSeg("seg1", seg1, expSeg[1]);
    checkSeg("seg2", seg2, expSeg[2]);
    checkSeg("seg3", seg3, expSeg[3]);
    checkSeg("seg4", seg4, expSeg[4]);
    checkSeg("seg5", seg5, expSeg[5]);
    checkSeg("seg6", seg6, expSeg[6]);
  endtask

  task automatic pushImm(input mythIsaPkg::opcodeT op, input mythCorePkg::dataT value);
    progQ.push_back(op);
    progQ.push_back(value);
  endtask

  task automatic pushRandomInstr();
    mythCorePkg::dataT pick;
    mythCorePkg::dataT sub;
    pick = randByte();
    sub = randByte();
    case (pick[2:0])
      3'd0: progQ.push_back(mythIsaPkg::opcIda + {4'h0, sub[3:0]});
      3'd1: progQ.push_back(mythIsaPkg::opcP4 + {5'h00, sub[2:0]});
      3'd2: pushImm(sub[0] ? mythIsaPkg::opcNr : (sub[1] ? mythIsaPkg::opcNa
                    : mythIsaPkg::opcNb), randByte());
      3'd3: progQ.push_back(sub[0] ? mythIsaPkg::opcRa : mythIsaPkg::opcRb);
      3'd4: progQ.push_back(mythIsaPkg::opcRdy);
      3'd5: pushImm(sub[0] ? mythIsaPkg::opcNj : (sub[1] ? mythIsaPkg::opcNt
                    : mythIsaPkg::opcNf), randByte());
      3'd6: progQ.push_back(sub[0] ? mythIsaPkg::opcRj : (sub[1] ? mythIsaPkg::opcRt
                            : mythIsaPkg::opcRf));
      default: progQ.push_back(8'h20 + {2'b00, sub[5:0]}); // Dropped opcodes.
    endcase
  endtask

  task automatic runProgram(input int instrCount);
    for (int i = 0; i < 256; i++)
    begin
      image[i] = (i < progQ.size()) ? progQ[i] : mythIsaPkg::opcNop;
      mem[pcAddr(mythCorePkg::dataT'(i))] = image[i];
    end
    @(posedge clk);
    reset <= 1'b1;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    modelPc = 8'd0;
    modelA = 8'd0;
    modelB = 8'd0;
    modelR = 8'd0;
    for (int d = 1; d <= 6; d++)
      expSeg[d] = '1;
    repeat (instrCount)
    begin
      checkState();
      modelStep();
      repeat (3) @(negedge clk);
    end
    checkState();
  endtask

  // ************************************************************
  // Test sequence
  // ************************************************************

  initial
  begin
    mythCorePkg::dataT target;
    mythCorePkg::dataT rValue;
    int count;
    reset = 1'b1;

    // Blank display, fetch from 0, and dropped opcodes stepping by one.
    // The closing RDY shows whether they left A and B alone.
    progQ = {};
    pushImm(mythIsaPkg::opcNa, randByte());
    pushImm(mythIsaPkg::opcNb, randByte());
    progQ = {progQ, 8'h01, 8'h06, 8'h2A, 8'h47, 8'h5C, 8'h71, 8'h3E, mythIsaPkg::opcRdy};
    runProgram(12);

    repeat (8)
    begin
      progQ = {};
      pushImm(mythIsaPkg::opcNa, randByte());
      pushImm(mythIsaPkg::opcNb, randByte());
      progQ.push_back(mythIsaPkg::opcRdy);
      runProgram(3);
    end

    // ALU and ADJUST chains whose result is shown through A.
    repeat (8)
    begin
      progQ = {};
      pushImm(mythIsaPkg::opcNa, randByte());
      pushImm(mythIsaPkg::opcNb, randByte());
      pushImm(mythIsaPkg::opcNr, randByte());
      count = 5;
      repeat (14)
      begin
        rValue = randByte();
        if (rValue[7:6] == 2'b00)
          pushImm(rValue[0] ? mythIsaPkg::opcNa : mythIsaPkg::opcNb, randByte());
        else if (rValue[5])
          progQ.push_back(mythIsaPkg::opcIda + {4'h0, rValue[3:0]});
        else
          progQ.push_back(mythIsaPkg::opcP4 + {5'h00, rValue[2:0]});
        count++;
      end
      progQ.push_back(mythIsaPkg::opcRa);
      progQ.push_back(mythIsaPkg::opcRdy);
      runProgram(count);
    end

    // Conditional jumps on zero and nonzero R, then NJ.
    repeat (8)
    begin
      rValue = randByte();
      progQ = {};
      pushImm(mythIsaPkg::opcNr, rValue[0] ? 8'h00 : rValue);
      pushImm(rValue[1] ? mythIsaPkg::opcNt : mythIsaPkg::opcNf, randByte());
      pushImm(mythIsaPkg::opcNj, randByte());
      runProgram(5);
    end

    repeat (4)
    begin
      target = randByte();
      progQ = {};
      pushImm(mythIsaPkg::opcNj, target | 8'h80); // Lands in the global page.
      runProgram(3);
      progQ = {};
      pushImm(mythIsaPkg::opcNj, target & 8'h7F);
      runProgram(3);
    end

    // Mixed random programs with jumps anywhere in the pc range.
    repeat (10)
    begin
      progQ = {};
      repeat (30) pushRandomInstr();
      runProgram(60);
    end

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hdl
hdl/mythCorePkg.sv
hdl/mythIsaPkg.sv
hdl/fetchUnit.sv
hdl/execUnit.sv
hdl/segDisplay.sv
hdl/mythCore.sv
tests/mythCoreTb.sv
